// File: design/dpcm_pkg.sv
// Shared widths, register map, address scaling and rate table for the DPCM channel RTL
`default_nettype none

package dpcm_pkg;

	localparam int DATA_WIDTH        = 8;  // Register write data and status
	localparam int ADDR_WIDTH        = 16;
	localparam int LEVEL_WIDTH       = 7;
	localparam int LEN_WIDTH         = 12;
	localparam int RATE_PERIOD_WIDTH = 9;
	localparam int BIT_CNT_WIDTH     = 4;  // Holds 0..8

	typedef logic [3:0]                   rate_index_t;
	typedef logic [DATA_WIDTH-1:0]        sample_byte_t;
	typedef logic [ADDR_WIDTH-1:0]        dmc_addr_t;
	typedef logic [LEVEL_WIDTH-1:0]       out_level_t;
	typedef logic [LEN_WIDTH-1:0]         bytes_left_t;
	typedef logic [2:0]                   reg_offset_t;

	// Tick period in aclk cycles, one entry per rate index
	localparam logic [RATE_PERIOD_WIDTH-1:0] RATE_TABLE [16] = '{
		9'd214, 9'd190, 9'd170, 9'd160,
		9'd143, 9'd127, 9'd113, 9'd107,
		9'd95,  9'd80,  9'd71,  9'd64,
		9'd53,  9'd42,  9'd36,  9'd27
	};

	localparam reg_offset_t REG_CTRL   = 3'd0;
	localparam reg_offset_t REG_LOAD   = 3'd1;
	localparam reg_offset_t REG_ADDR   = 3'd2;
	localparam reg_offset_t REG_LEN    = 3'd3;
	localparam reg_offset_t REG_STATUS = 3'd5;

	localparam dmc_addr_t ADDR_BASE = 16'hC000;  // Sample start base
	localparam dmc_addr_t ADDR_WRAP = 16'h8000;  // Counter target after 16'hFFFF
	localparam int ADDR_SHIFT = 6;               // Start = base + code * 64
	localparam int LEN_SHIFT  = 4;               // Bytes = code * 16 + 1

	localparam int LEVEL_STEP    = 2;
	localparam int LEVEL_MAX     = 127;
	localparam int BITS_PER_BYTE = 8;

endpackage

`default_nettype wire

// File: design/dpcm_cfg_if.sv
// Configuration and sample progress shared by the register block and the DPCM datapath
`timescale 1ns/1ps
`default_nettype none

interface dpcm_cfg_if;
	import dpcm_pkg::*;

	rate_index_t rate_index;
	logic        loop_mode;
	dmc_addr_t   start_addr;    // Already scaled
	bytes_left_t start_len;     // Already scaled
	logic        restart;       // Pulse
	logic        stop;          // Pulse
	logic        level_load;    // Pulse
	out_level_t  level_value;
	logic        bytes_active;
	logic        sample_done;   // Pulse at non-looping end

	modport regs (
		output rate_index, loop_mode, start_addr, start_len,
		output restart, stop, level_load, level_value,
		input  bytes_active, sample_done
	);

	modport timer (input rate_index);

	modport reader (
		input  loop_mode, start_addr, start_len, restart, stop,
		output bytes_active, sample_done
	);

	modport output_unit (input level_load, level_value);

endinterface

`default_nettype wire

// File: design/dpcm_regs.sv
// Register write decode for the DPCM channel, holds config, enable commands and interrupt flag
`timescale 1ns/1ps
`default_nettype none

module dpcm_regs (
	input  logic                              aclk,
	input  logic                              reset,
	input  logic                              reg_write,
	input  dpcm_pkg::reg_offset_t             reg_addr,
	input  logic [dpcm_pkg::DATA_WIDTH-1:0]   reg_wdata,
	dpcm_cfg_if.regs                          cfg,
	output logic [dpcm_pkg::DATA_WIDTH-1:0]   status,
	output logic                              irq
);
	import dpcm_pkg::*;

	logic                  irq_en;
	logic                  irq_flag;
	logic [DATA_WIDTH-1:0] addr_code;
	logic [DATA_WIDTH-1:0] len_code;

	always_ff @(posedge aclk) begin
		if (reset) begin
			cfg.rate_index <= '0;
			cfg.loop_mode  <= 1'b0;
			irq_en         <= 1'b0;
			irq_flag       <= 1'b0;
			addr_code      <= '0;
			len_code       <= '0;
			cfg.restart    <= 1'b0;
			cfg.stop       <= 1'b0;
			cfg.level_load <= 1'b0;
		end else begin
			cfg.restart    <= 1'b0;
			cfg.stop       <= 1'b0;
			cfg.level_load <= 1'b0;
			if (cfg.sample_done && irq_en)
				irq_flag <= 1'b1;
			if (reg_write) begin
				case (reg_addr)
					REG_CTRL: begin
						cfg.rate_index <= reg_wdata[3:0];
						cfg.loop_mode  <= reg_wdata[6];
						irq_en         <= reg_wdata[7];
						if (!reg_wdata[7])
							irq_flag <= 1'b0;  // Disabling drops a pending flag
					end
					REG_LOAD:   cfg.level_load <= 1'b1;
					REG_ADDR:   addr_code <= reg_wdata;
					REG_LEN:    len_code <= reg_wdata;
					REG_STATUS: begin
						irq_flag <= 1'b0;
						if (reg_wdata[4])
							cfg.restart <= !cfg.bytes_active;  // Only from idle
						else
							cfg.stop <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (reg_write && reg_addr == REG_LOAD)
			cfg.level_value <= reg_wdata[LEVEL_WIDTH-1:0];
	end

	assign cfg.start_addr = ADDR_BASE + (dmc_addr_t'(addr_code) << ADDR_SHIFT);
	assign cfg.start_len  = (bytes_left_t'(len_code) << LEN_SHIFT) + bytes_left_t'(1);

	assign status = {irq_flag, 2'b00, cfg.bytes_active, 4'b0000};
	assign irq    = irq_flag;

endmodule

`default_nettype wire

// File: design/dpcm_rate_timer.sv
// Rate table lookup and down-counter that paces the DPCM output unit with one-cycle ticks
`timescale 1ns/1ps
`default_nettype none

module dpcm_rate_timer (
	input  logic       aclk,
	input  logic       reset,
	dpcm_cfg_if.timer  cfg,
	output logic       tick
);
	import dpcm_pkg::*;

	logic [RATE_PERIOD_WIDTH-1:0] count;
	logic [RATE_PERIOD_WIDTH-1:0] period;

	assign period = RATE_TABLE[cfg.rate_index];  // New index used at next reload

	always_ff @(posedge aclk) begin
		if (reset)
			count <= '0;
		else if (count == '0)
			count <= period - 1'b1;
		else
			count <= count - 1'b1;
	end

	assign tick = (count == '0);

	// Shortest period is 27 cycles, ticks are always isolated
	tick_isolated: assert property (
		@(posedge aclk) disable iff (reset)
		tick |=> !tick
	);

endmodule

`default_nettype wire

// File: design/dpcm_sample_reader.sv
// DPCM sample fetch: address and length counters, request/acknowledge handshake, one-byte buffer
`timescale 1ns/1ps
`default_nettype none

module dpcm_sample_reader (
	input  logic                   aclk,
	input  logic                   reset,
	dpcm_cfg_if.reader             cfg,
	output logic                   dma_req,
	output dpcm_pkg::dmc_addr_t    dma_addr,
	input  logic                   dma_ack,
	input  dpcm_pkg::sample_byte_t dma_data,
	output logic                   buf_full,
	output dpcm_pkg::sample_byte_t buf_data,
	input  logic                   buf_take
);
	import dpcm_pkg::*;

	dmc_addr_t   addr_cnt;
	bytes_left_t bytes_left;
	logic        req_start;
	logic        dma_done;
	logic        last_byte;

	assign req_start = !dma_req && cfg.bytes_active && !buf_full;
	assign dma_done  = dma_req && dma_ack;
	assign last_byte = (bytes_left == bytes_left_t'(1));

	always_ff @(posedge aclk) begin
		if (reset) begin
			dma_req          <= 1'b0;
			buf_full         <= 1'b0;
			bytes_left       <= '0;
			cfg.bytes_active <= 1'b0;
			cfg.sample_done  <= 1'b0;
		end else begin
			cfg.sample_done <= 1'b0;
			if (dma_done) begin
				dma_req  <= 1'b0;
				buf_full <= 1'b1;
				if (cfg.bytes_active) begin
					if (!last_byte) begin
						bytes_left <= bytes_left - 1'b1;
					end else if (cfg.loop_mode) begin
						bytes_left <= cfg.start_len;  // Loop reload
					end else begin
						bytes_left       <= '0;
						cfg.bytes_active <= 1'b0;
						cfg.sample_done  <= 1'b1;
					end
				end
			end else if (req_start) begin
				dma_req <= 1'b1;
			end
			if (buf_take)
				buf_full <= 1'b0;
			if (cfg.stop) begin
				bytes_left       <= '0;
				cfg.bytes_active <= 1'b0;
			end else if (cfg.restart) begin
				bytes_left       <= cfg.start_len;
				cfg.bytes_active <= 1'b1;
			end
		end
	end

	// Address counter, request address and buffer contents
	always_ff @(posedge aclk) begin
		if (cfg.restart) begin
			addr_cnt <= cfg.start_addr;
		end else if (dma_done && cfg.bytes_active) begin
			if (last_byte && cfg.loop_mode)
				addr_cnt <= cfg.start_addr;
			else if (addr_cnt == '1)
				addr_cnt <= ADDR_WRAP;  // Top of memory wraps into 8000
			else
				addr_cnt <= addr_cnt + 1'b1;
		end
		if (req_start)
			dma_addr <= addr_cnt;  // Held for the whole request
		if (dma_done)
			buf_data <= dma_data;
	end

	req_addr_held: assert property (
		@(posedge aclk) disable iff (reset)
		(dma_req && !dma_ack) |=> (dma_req && $stable(dma_addr))
	);

endmodule

`default_nettype wire

// File: design/dpcm_output_unit.sv
// DPCM output stage: shifts sample bits out and steps the 7-bit level, with direct level load
`timescale 1ns/1ps
`default_nettype none

module dpcm_output_unit (
	input  logic                   aclk,
	input  logic                   reset,
	dpcm_cfg_if.output_unit        cfg,
	input  logic                   tick,
	input  logic                   buf_full,
	input  dpcm_pkg::sample_byte_t buf_data,
	output logic                   buf_take,
	output dpcm_pkg::out_level_t   dmc_out
);
	import dpcm_pkg::*;

	sample_byte_t             shift_reg;
	logic [BIT_CNT_WIDTH-1:0] bit_cnt;
	logic                     silent;
	out_level_t               level;
	out_level_t               level_next;
	logic                     byte_end;

	assign byte_end = tick && (bit_cnt == BIT_CNT_WIDTH'(1));
	assign buf_take = byte_end && buf_full;  // Buffer empties at this edge

	// Saturating step from the low shift register bit
	always_comb begin
		level_next = level;
		if (shift_reg[0]) begin
			if (level <= LEVEL_MAX - LEVEL_STEP)
				level_next = level + out_level_t'(LEVEL_STEP);
		end else if (level >= LEVEL_STEP) begin
			level_next = level - out_level_t'(LEVEL_STEP);
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			bit_cnt <= BIT_CNT_WIDTH'(BITS_PER_BYTE);
			silent  <= 1'b1;
			level   <= '0;
		end else begin
			if (cfg.level_load)
				level <= cfg.level_value;  // Load beats a same-cycle step
			else if (tick && !silent)
				level <= level_next;
			if (byte_end) begin
				bit_cnt <= BIT_CNT_WIDTH'(BITS_PER_BYTE);
				silent  <= !buf_full;  // Starved buffer means a silent byte
			end else if (tick) begin
				bit_cnt <= bit_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (buf_take)
			shift_reg <= buf_data;
		else if (tick)
			shift_reg <= shift_reg >> 1;
	end

	assign dmc_out = level;

	level_step_bound: assert property (
		@(posedge aclk) disable iff (reset)
		(tick && !silent && !cfg.level_load) |=>
			(level == $past(level)) ||
			(level == $past(level) + out_level_t'(LEVEL_STEP)) ||
			(level == $past(level) - out_level_t'(LEVEL_STEP))
	);

endmodule

`default_nettype wire

// File: design/dpcm_channel.sv
// DPCM sample channel top level, connects registers, rate timer, reader and output unit
`timescale 1ns/1ps
`default_nettype none

module dpcm_channel (
	input  logic                            aclk,
	input  logic                            reset,
	input  logic                            reg_write,
	input  dpcm_pkg::reg_offset_t           reg_addr,
	input  logic [dpcm_pkg::DATA_WIDTH-1:0] reg_wdata,
	output logic [dpcm_pkg::DATA_WIDTH-1:0] status,
	output logic                            dma_req,
	output dpcm_pkg::dmc_addr_t             dma_addr,
	input  logic                            dma_ack,
	input  dpcm_pkg::sample_byte_t          dma_data,
	output logic                            irq,
	output dpcm_pkg::out_level_t            dmc_out
);
	import dpcm_pkg::*;

	logic         tick;
	logic         buf_full;
	logic         buf_take;
	sample_byte_t buf_data;

	dpcm_cfg_if cfg_if ();

	dpcm_regs i_regs (
		.aclk      (aclk),
		.reset     (reset),
		.reg_write (reg_write),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.cfg       (cfg_if.regs),
		.status    (status),
		.irq       (irq)
	);

	dpcm_rate_timer i_rate_timer (.aclk(aclk), .reset(reset), .cfg(cfg_if.timer), .tick(tick));

	dpcm_sample_reader i_sample_reader (
		.aclk     (aclk),
		.reset    (reset),
		.cfg      (cfg_if.reader),
		.dma_req  (dma_req),
		.dma_addr (dma_addr),
		.dma_ack  (dma_ack),
		.dma_data (dma_data),
		.buf_full (buf_full),
		.buf_data (buf_data),
		.buf_take (buf_take)
	);

	dpcm_output_unit i_output_unit (
		.aclk     (aclk),
		.reset    (reset),
		.cfg      (cfg_if.output_unit),
		.tick     (tick),
		.buf_full (buf_full),
		.buf_data (buf_data),
		.buf_take (buf_take),
		.dmc_out  (dmc_out)
	);

endmodule

`default_nettype wire

// File: include/tb_dpcm_tasks.svh
// Directed DPCM channel tests, included into the testbench top module
`ifndef TB_DPCM_TASKS_SVH
`define TB_DPCM_TASKS_SVH

task automatic reset_state_test();
	apply_reset();
	check_value("reset_state dmc_out", 0, dmc_out);
	check_value("reset_state dma_req", 0, dma_req);
	check_value("reset_state irq", 0, irq);
	check_value("reset_state status", 0, status);
endtask

task automatic direct_load_test();
	logic [7:0] value;
	apply_reset();
	repeat (8) begin
		value = 8'(next_random_bits(8));
		write_reg(REG_LOAD, value);
		@(negedge aclk);  // Level follows one cycle after the write
		check_value("direct_load", value[6:0], dmc_out);
	end
endtask

// Start FFC0, 65 bytes, runs past FFFF into 8000
task automatic fetch_order_test();
	logic [31:0] expected;
	apply_reset();
	write_reg(REG_CTRL, 8'h8F);
	write_reg(REG_ADDR, 8'hFF);
	write_reg(REG_LEN, 8'h04);
	write_reg(REG_STATUS, 8'h10);
	while (!irq)
		@(negedge aclk);
	check_value("fetch_order count", 65, addr_log.size());
	for (int i = 0; i < 65; i++) begin
		expected = 32'hFFC0 + i;
		if (expected > 32'hFFFF)
			expected = expected - 32'h10000 + 32'h8000;
		check_value("fetch_order address", expected, addr_log[i]);
	end
	repeat (2 * BITS_PER_BYTE * FAST_PERIOD) begin
		@(negedge aclk);
		check_value("fetch_order idle", 0, dma_req);
	end
	check_value("fetch_order status", 8'h80, status);
	check_value("fetch_order irq", 1, irq);
	write_reg(REG_STATUS, 8'h00);
	check_value("fetch_order irq clear", 0, irq);
endtask

// Length code 1 plays 17 bytes
task automatic output_step_test();
	logic [6:0] model;
	logic [6:0] seen;
	logic [6:0] next;
	int         bit_idx;
	int         settle;
	apply_reset();
	write_reg(REG_LOAD, 8'd64);
	@(negedge aclk);
	check_value("output_step load", 64, dmc_out);
	model   = 7'd64;
	seen    = 7'd64;
	bit_idx = 0;
	settle  = 0;
	write_reg(REG_CTRL, 8'h8F);
	write_reg(REG_ADDR, 8'h21);
	write_reg(REG_LEN, 8'h01);
	write_reg(REG_STATUS, 8'h10);
	while (settle < (2 * BITS_PER_BYTE + 1) * FAST_PERIOD) begin  // Drain shift reg and buffer
		@(negedge aclk);
		if (irq)
			settle++;
		if (dmc_out !== seen) begin
			next = model;
			while (next == model && bit_idx < data_log.size() * 8) begin  // Skip saturated bits
				next = step_level(model, data_log[bit_idx / 8][bit_idx % 8]);
				bit_idx++;
			end
			check_value("output_step change", next, dmc_out);
			model = next;
			seen  = dmc_out;
		end
	end
	while (bit_idx < data_log.size() * 8) begin
		model = step_level(model, data_log[bit_idx / 8][bit_idx % 8]);
		bit_idx++;
	end
	check_value("output_step bytes", 17, data_log.size());
	check_value("output_step final", model, dmc_out);
endtask

function automatic logic [6:0] step_level(input logic [6:0] level, input logic b);
	if (b && level <= 7'd125)
		return level + 7'd2;
	if (!b && level >= 7'd2)
		return level - 7'd2;
	return level;
endfunction

task automatic loop_test();
	apply_reset();
	write_reg(REG_CTRL, 8'hCF);
	write_reg(REG_ADDR, 8'h10);  // Start C400
	write_reg(REG_LEN, 8'h00);
	write_reg(REG_STATUS, 8'h10);
	while (addr_log.size() < 5) begin
		@(negedge aclk);
		check_value("loop irq", 0, irq);
	end
	foreach (addr_log[i])
		check_value("loop address", 16'hC400, addr_log[i]);
	check_value("loop status", 8'h10, status);
	write_reg(REG_STATUS, 8'h00);
	while (dma_req)
		@(negedge aclk);  // A request in flight still gets its ack
	repeat (3 * BITS_PER_BYTE * FAST_PERIOD) begin
		@(negedge aclk);
		check_value("loop stopped", 0, dma_req);
	end
endtask

task automatic irq_clear_test();
	apply_reset();
	write_reg(REG_CTRL, 8'h8F);
	write_reg(REG_ADDR, 8'h05);
	write_reg(REG_LEN, 8'h00);
	write_reg(REG_STATUS, 8'h10);
	while (!irq)
		@(negedge aclk);
	check_value("irq_clear status", 8'h80, status);
	write_reg(REG_CTRL, 8'h0F);
	check_value("irq_clear irq", 0, irq);
endtask

`endif

// File: tb/tb_dpcm_channel.sv
// Testbench top for the DPCM channel, runs the directed tests included from the task header
`timescale 1ns/1ps
`default_nettype none

module tb_dpcm_channel;
	import dpcm_pkg::*;

	localparam int TIMEOUT_CYCLES = 60000;  // About twice 120 bytes * 8 bits * 27 cycles
	localparam int FAST_PERIOD    = 27;     // Rate index 15

	logic                  aclk;
	logic                  reset;
	logic                  reg_write;
	reg_offset_t           reg_addr;
	logic [DATA_WIDTH-1:0] reg_wdata;
	logic [DATA_WIDTH-1:0] status;
	logic                  dma_req;
	dmc_addr_t             dma_addr;
	logic                  dma_ack;
	sample_byte_t          dma_data;
	logic                  irq;
	out_level_t            dmc_out;

	logic [31:0]  lfsr_state = 32'h9c6;
	logic [7:0]   sample_mem [256];
	dmc_addr_t    addr_log [$];  // Every acknowledged fetch address
	sample_byte_t data_log [$];  // Bytes handed out, in fetch order
	int           cycle_count = 0;

	dpcm_channel i_dpcm_channel (
		.aclk      (aclk),
		.reset     (reset),
		.reg_write (reg_write),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.status    (status),
		.dma_req   (dma_req),
		.dma_addr  (dma_addr),
		.dma_ack   (dma_ack),
		.dma_data  (dma_data),
		.irq       (irq),
		.dmc_out   (dmc_out)
	);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] next_random_bits(input int count);
		logic [31:0] result;
		logic        out_bit;
		result = '0;
		for (int i = 0; i < count; i++) begin
			out_bit    = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit)
				lfsr_state = lfsr_state ^ 32'hA300_0000;
			result = {result[30:0], out_bit};
		end
		return result;
	endfunction

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("ERROR %s expected %0h actual %0h", name, expected, actual));
	endtask

	task automatic apply_reset();
		@(negedge aclk);
		reset = 1'b1;
		repeat (3) @(negedge aclk);
		reset = 1'b0;
		addr_log.delete();
		data_log.delete();
	endtask

	task automatic write_reg(input reg_offset_t offset, input logic [7:0] value);
		@(negedge aclk);
		reg_write = 1'b1;
		reg_addr  = offset;
		reg_wdata = value;
		@(negedge aclk);
		reg_write = 1'b0;  // Register took the value at the edge just passed
	endtask

	// Memory model, answers each request after 0 to 7 cycles
	initial begin : memory_responder
		int delay;
		forever begin
			@(negedge aclk);
			if (dma_req && !reset) begin
				delay = next_random_bits(3);
				repeat (delay) @(negedge aclk);
				dma_data = sample_mem[dma_addr[7:0]] ^ dma_addr[15:8];  // Whole address matters
				addr_log.push_back(dma_addr);
				data_log.push_back(dma_data);
				dma_ack = 1'b1;
				@(negedge aclk);
				dma_ack = 1'b0;
			end
		end
	end

	always @(posedge aclk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			report_failure("Timeout, the tests did not finish within the cycle limit");
	end

	`include "tb_dpcm_tasks.svh"

	initial begin : test_sequence
		reset     = 1'b1;
		reg_write = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;
		dma_ack   = 1'b0;
		dma_data  = '0;
		foreach (sample_mem[i])
			sample_mem[i] = 8'(next_random_bits(8));
		reset_state_test();
		direct_load_test();
		fetch_order_test();
		output_step_test();
		loop_test();
		irq_clear_test();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dpcm_channel.f
+incdir+include
design/dpcm_pkg.sv
design/dpcm_cfg_if.sv
design/dpcm_regs.sv
design/dpcm_rate_timer.sv
design/dpcm_sample_reader.sv
design/dpcm_output_unit.sv
design/dpcm_channel.sv
tb/tb_dpcm_channel.sv
